/* hdl/exe_pkg.sv */
package exe_pkg;

    localparam int xlen = 32;
    localparam int pp_w = 34;   // 17x17 signed partial product

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [1:0] {
        kind_alu    = 2'd0,
        kind_mul    = 2'd1,
        kind_branch = 2'd2
    } kind_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_nor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_t;

    typedef enum logic [3:0] {
        br_jirl = 4'b0011,
        br_b    = 4'b0100,
        br_bl   = 4'b0101,
        br_beq  = 4'b0110,
        br_bne  = 4'b0111,
        br_blt  = 4'b1000,
        br_bge  = 4'b1001,
        br_bltu = 4'b1010,
        br_bgeu = 4'b1011
    } br_cond_t;

    typedef struct packed {
        kind_t    kind;
        alu_op_t  alu_op;
        br_cond_t cond;
        logic     use_imm;     // imm replaces source 1
        logic     mul_hi;
        logic     mul_usign;
    } uop_t;

    typedef struct packed {
        logic            en;
        reg_addr_t       rd;
        logic [xlen-1:0] data;
    } lane_res_t;

    // pp[3] hi*hi, pp[2] hi*lo, pp[1] lo*hi, pp[0] lo*lo
    typedef struct packed {
        logic [3:0][pp_w-1:0] pp;
        logic                 mul_hi;
    } part_prod_t;

    typedef struct packed {
        lane_res_t       lane0;
        lane_res_t       lane1;
        logic            is_mul;
        part_prod_t      prod;
        logic [xlen-1:0] pc;
    } front_slot_t;

    typedef struct packed {
        lane_res_t       lane0;
        lane_res_t       lane1;
        logic [xlen-1:0] pc;
    } wb_slot_t;

endpackage

/* hdl/exe_bypass_if.sv */
interface exe_bypass_if import exe_pkg::*; ();

    // en already qualified by the entry's valid
    lane_res_t s1_lane0;
    lane_res_t s1_lane1;
    logic      s1_mul_pending;    // lane 0 of stage 1 still needs the merge
    lane_res_t s2_lane0;
    lane_res_t s2_lane1;

    modport src (
        output s1_lane0,
        output s1_lane1,
        output s1_mul_pending,
        output s2_lane0,
        output s2_lane1
    );

    modport sink (
        input s1_lane0,
        input s1_lane1,
        input s1_mul_pending,
        input s2_lane0,
        input s2_lane1
    );

endinterface

/* hdl/exe_alu.sv */
module exe_alu import exe_pkg::*; (
    input  alu_op_t         op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, a < b};
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_nor: begin
                result = ~(a | b);
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                result = $signed(a) >>> shamt;
            end
            alu_lui: begin
                result = b << 12;    // imm already in b
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* hdl/exe_branch.sv */
module exe_branch import exe_pkg::*; (
    input  br_cond_t        cond,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] pc_next,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] src0,
    input  logic [xlen-1:0] src1,
    output logic            taken,
    output logic [xlen-1:0] target,
    output logic [xlen-1:0] link,
    output logic            mispredict
);

    logic [xlen-1:0] base;
    logic [xlen-1:0] next_pc;

    always_comb begin
        case (cond)
            br_jirl, br_b, br_bl: begin
                taken = 1'b1;
            end
            br_beq: begin
                taken = src0 == src1;
            end
            br_bne: begin
                taken = src0 != src1;
            end
            br_blt: begin
                taken = $signed(src0) < $signed(src1);
            end
            br_bge: begin
                taken = $signed(src0) >= $signed(src1);
            end
            br_bltu: begin
                taken = src0 < src1;
            end
            br_bgeu: begin
                taken = src0 >= src1;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    assign base    = (cond == br_jirl) ? src0 : pc;  // jirl is register relative
    assign target  = base + imm;
    assign link    = pc + xlen'(4);
    assign next_pc = taken ? target : link;

    // predictor guessed pc_next at fetch
    assign mispredict = next_pc != pc_next;

endmodule

/* hdl/exe_front.sv */
module exe_front import exe_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            in_valid,
    output logic            in_ready,
    input  logic            lane0_en,
    input  uop_t            lane0_uop,
    input  reg_addr_t       lane0_rd,
    input  reg_addr_t       lane0_rj,
    input  reg_addr_t       lane0_rk,
    input  logic [xlen-1:0] lane0_imm,
    input  logic [xlen-1:0] lane0_pc,
    input  logic [xlen-1:0] lane0_pc_next,
    input  logic [xlen-1:0] lane0_src0,
    input  logic [xlen-1:0] lane0_src1,
    input  logic            lane1_en,
    input  uop_t            lane1_uop,
    input  reg_addr_t       lane1_rd,
    input  reg_addr_t       lane1_rj,
    input  reg_addr_t       lane1_rk,
    input  logic [xlen-1:0] lane1_imm,
    input  logic [xlen-1:0] lane1_src0,
    input  logic [xlen-1:0] lane1_src1,
    exe_bypass_if.sink      bypass,
    output logic            out_valid,
    input  logic            out_ready,
    output front_slot_t     out_slot,
    output logic            redirect_valid,
    output logic [xlen-1:0] redirect_pc,
    output logic            branch_taken
);

    logic [xlen-1:0] l0_a, l0_b, l1_a, l1_b;
    logic [xlen-1:0] alu0_b, alu1_b, alu0_res, alu1_res;
    logic            stall, fire, is_br, is_mul;
    logic            br_taken, br_mispredict;
    logic [xlen-1:0] br_target, br_link;
    logic [32:0]     a33, b33;
    logic signed [16:0] a_hi, a_lo, b_hi, b_lo;

    function automatic logic hit(input lane_res_t l, input reg_addr_t r);
        return l.en && (l.rd != '0) && (l.rd == r);
    endfunction

    // newest producer first, lane 1 is younger than lane 0
    function automatic logic [xlen-1:0] fwd(input reg_addr_t r, input logic [xlen-1:0] rf);
        if (hit(bypass.s1_lane1, r)) return bypass.s1_lane1.data;
        if (hit(bypass.s1_lane0, r)) return bypass.s1_lane0.data;
        if (hit(bypass.s2_lane1, r)) return bypass.s2_lane1.data;
        if (hit(bypass.s2_lane0, r)) return bypass.s2_lane0.data;
        return rf;
    endfunction

    function automatic logic mul_hit(input reg_addr_t r);
        return bypass.s1_mul_pending && hit(bypass.s1_lane0, r) && !hit(bypass.s1_lane1, r);
    endfunction

    always_comb begin
        l0_a  = fwd(lane0_rj, lane0_src0);
        l0_b  = fwd(lane0_rk, lane0_src1);
        l1_a  = fwd(lane1_rj, lane1_src0);
        l1_b  = fwd(lane1_rk, lane1_src1);
        stall = (lane0_en && (mul_hit(lane0_rj) || mul_hit(lane0_rk)))
             || (lane1_en && (mul_hit(lane1_rj) || mul_hit(lane1_rk)));
    end

    assign out_valid = in_valid && !stall;
    assign in_ready  = out_ready && !stall;
    assign fire      = in_valid && in_ready;

    assign alu0_b = lane0_uop.use_imm ? lane0_imm : l0_b;
    assign alu1_b = lane1_uop.use_imm ? lane1_imm : l1_b;

    exe_alu u_alu0 (.op(lane0_uop.alu_op), .a(l0_a), .b(alu0_b), .result(alu0_res));
    exe_alu u_alu1 (.op(lane1_uop.alu_op), .a(l1_a), .b(alu1_b), .result(alu1_res));

    exe_branch u_branch (
        .cond       (lane0_uop.cond),
        .pc         (lane0_pc),
        .pc_next    (lane0_pc_next),
        .imm        (lane0_imm),
        .src0       (l0_a),
        .src1       (l0_b),
        .taken      (br_taken),
        .target     (br_target),
        .link       (br_link),
        .mispredict (br_mispredict)
    );

    assign is_br  = lane0_en && (lane0_uop.kind == kind_branch);
    assign is_mul = lane0_en && (lane0_uop.kind == kind_mul);

    assign redirect_valid = fire && is_br && br_mispredict;
    assign redirect_pc    = br_taken ? br_target : br_link;
    assign branch_taken   = fire && is_br && br_taken;

    // 33-bit operands so one signed multiplier covers both signednesses
    assign a33  = {!lane0_uop.mul_usign && l0_a[xlen-1], l0_a};
    assign b33  = {!lane0_uop.mul_usign && l0_b[xlen-1], l0_b};
    assign a_hi = a33[32:16];
    assign a_lo = {1'b0, a33[15:0]};
    assign b_hi = b33[32:16];
    assign b_lo = {1'b0, b33[15:0]};

    always_comb begin
        out_slot.lane0.rd   = lane0_rd;
        out_slot.lane0.en   = lane0_en;
        out_slot.lane0.data = alu0_res;
        if (lane0_uop.kind == kind_mul) begin
            out_slot.lane0.data = '0;   // filled by the merge
        end else if (lane0_uop.kind == kind_branch) begin
            out_slot.lane0.data = br_link;
            out_slot.lane0.en   = lane0_en
                && (lane0_uop.cond == br_bl || lane0_uop.cond == br_jirl);
        end
        out_slot.lane1.en    = lane1_en && !(is_br && br_mispredict);
        out_slot.lane1.rd    = lane1_rd;
        out_slot.lane1.data  = alu1_res;
        out_slot.is_mul      = is_mul;
        out_slot.prod.pp[3]  = a_hi * b_hi;
        out_slot.prod.pp[2]  = a_hi * b_lo;
        out_slot.prod.pp[1]  = a_lo * b_hi;
        out_slot.prod.pp[0]  = a_lo * b_lo;
        out_slot.prod.mul_hi = lane0_uop.mul_hi;
        out_slot.pc          = lane0_pc;
    end

    a_redirect_kills_lane1: assert property (@(posedge clk) disable iff (!rstn)
        redirect_valid |=> !bypass.s1_lane1.en)
        else $error("lane 1 of a mispredicted bundle reached stage 1");

endmodule

/* hdl/exe_slot_buf.sv */
module exe_slot_buf #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // empty, or the current entry leaves this cycle
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

    a_hold_stable: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("slot content changed while stalled");

endmodule

/* hdl/exe_back.sv */
module exe_back import exe_pkg::*; (
    input  logic        in_valid,
    output logic        in_ready,
    input  front_slot_t in_slot,
    output logic        out_valid,
    input  logic        out_ready,
    output wb_slot_t    out_slot,
    input  wb_slot_t    wb_view,
    input  logic        wb_view_valid,
    exe_bypass_if.src   bypass
);

    logic signed [63:0] pp_hh, pp_hl, pp_lh, pp_ll;
    logic        [63:0] product;

    // sign extension to 64 bits happens on assignment
    assign pp_hh = $signed(in_slot.prod.pp[3]);
    assign pp_hl = $signed(in_slot.prod.pp[2]);
    assign pp_lh = $signed(in_slot.prod.pp[1]);
    assign pp_ll = $signed(in_slot.prod.pp[0]);

    assign product = (pp_hh <<< 32) + ((pp_hl + pp_lh) <<< 16) + pp_ll;

    always_comb begin
        out_slot.lane0 = in_slot.lane0;
        out_slot.lane1 = in_slot.lane1;
        out_slot.pc    = in_slot.pc;
        if (in_slot.is_mul) begin
            out_slot.lane0.data = in_slot.prod.mul_hi ? product[63:32] : product[31:0];
        end
    end

    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    // stage 1 view, lane 0 data is only meaningful for non multiply ops
    always_comb begin
        bypass.s1_lane0         = in_slot.lane0;
        bypass.s1_lane0.en      = in_valid && in_slot.lane0.en;
        bypass.s1_lane1         = in_slot.lane1;
        bypass.s1_lane1.en      = in_valid && in_slot.lane1.en;
        bypass.s1_mul_pending   = in_valid && in_slot.is_mul;
    end

    always_comb begin
        bypass.s2_lane0    = wb_view.lane0;
        bypass.s2_lane0.en = wb_view_valid && wb_view.lane0.en;
        bypass.s2_lane1    = wb_view.lane1;
        bypass.s2_lane1.en = wb_view_valid && wb_view.lane1.en;
    end

endmodule

/* hdl/exe_top.sv */
module exe_top import exe_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            in_valid,
    output logic            in_ready,
    input  logic            lane0_en,
    input  uop_t            lane0_uop,
    input  reg_addr_t       lane0_rd,
    input  reg_addr_t       lane0_rj,
    input  reg_addr_t       lane0_rk,
    input  logic [xlen-1:0] lane0_imm,
    input  logic [xlen-1:0] lane0_pc,
    input  logic [xlen-1:0] lane0_pc_next,
    input  logic [xlen-1:0] lane0_src0,
    input  logic [xlen-1:0] lane0_src1,
    input  logic            lane1_en,
    input  uop_t            lane1_uop,
    input  reg_addr_t       lane1_rd,
    input  reg_addr_t       lane1_rj,
    input  reg_addr_t       lane1_rk,
    input  logic [xlen-1:0] lane1_imm,
    input  logic [xlen-1:0] lane1_src0,
    input  logic [xlen-1:0] lane1_src1,
    output logic            out_valid,
    input  logic            out_ready,
    output logic            wb0_en,
    output reg_addr_t       wb0_rd,
    output logic [xlen-1:0] wb0_data,
    output logic            wb1_en,
    output reg_addr_t       wb1_rd,
    output logic [xlen-1:0] wb1_data,
    output logic [xlen-1:0] wb0_pc,
    output logic            redirect_valid,
    output logic [xlen-1:0] redirect_pc,
    output logic            branch_taken
);

    logic        f_valid, f_ready, s1_valid, s1_ready, b_valid, b_ready;
    front_slot_t f_slot, s1_slot;
    wb_slot_t    b_slot, wb;

    exe_bypass_if u_bypass ();

    exe_front u_front (
        .clk(clk), .rstn(rstn), .in_valid(in_valid), .in_ready(in_ready),
        .lane0_en(lane0_en), .lane0_uop(lane0_uop), .lane0_rd(lane0_rd),
        .lane0_rj(lane0_rj), .lane0_rk(lane0_rk), .lane0_imm(lane0_imm),
        .lane0_pc(lane0_pc), .lane0_pc_next(lane0_pc_next),
        .lane0_src0(lane0_src0), .lane0_src1(lane0_src1),
        .lane1_en(lane1_en), .lane1_uop(lane1_uop), .lane1_rd(lane1_rd),
        .lane1_rj(lane1_rj), .lane1_rk(lane1_rk), .lane1_imm(lane1_imm),
        .lane1_src0(lane1_src0), .lane1_src1(lane1_src1),
        .bypass(u_bypass.sink),
        .out_valid(f_valid), .out_ready(f_ready), .out_slot(f_slot),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .branch_taken(branch_taken)
    );

    exe_slot_buf #(.payload_t(front_slot_t)) u_slot1 (
        .clk(clk), .rstn(rstn),
        .in_valid(f_valid), .in_ready(f_ready), .in_data(f_slot),
        .out_valid(s1_valid), .out_ready(s1_ready), .out_data(s1_slot)
    );

    exe_back u_back (
        .in_valid(s1_valid), .in_ready(s1_ready), .in_slot(s1_slot),
        .out_valid(b_valid), .out_ready(b_ready), .out_slot(b_slot),
        .wb_view(wb), .wb_view_valid(out_valid),
        .bypass(u_bypass.src)
    );

    exe_slot_buf #(.payload_t(wb_slot_t)) u_slot2 (
        .clk(clk), .rstn(rstn),
        .in_valid(b_valid), .in_ready(b_ready), .in_data(b_slot),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(wb)
    );

    assign wb0_en   = wb.lane0.en;
    assign wb0_rd   = wb.lane0.rd;
    assign wb0_data = wb.lane0.data;
    assign wb1_en   = wb.lane1.en;
    assign wb1_rd   = wb.lane1.rd;
    assign wb1_data = wb.lane1.data;
    assign wb0_pc   = wb.pc;

endmodule

/* bench/tb_exe.sv */
module tb_exe import exe_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_bundles   = 400;
    localparam int cycle_limit = n_bundles * 8 + 200;

    typedef struct packed {
        logic            en0;
        reg_addr_t       rd0;
        logic [xlen-1:0] d0;
        logic            en1;
        reg_addr_t       rd1;
        logic [xlen-1:0] d1;
        logic [xlen-1:0] pc;
    } expect_t;

    logic            clk = 1'b0;
    logic            rstn;
    logic            in_valid, in_ready, out_valid, out_ready;
    logic            lane0_en, lane1_en;
    uop_t            lane0_uop, lane1_uop;
    reg_addr_t       lane0_rd, lane0_rj, lane0_rk, lane1_rd, lane1_rj, lane1_rk;
    logic [xlen-1:0] lane0_imm, lane0_pc, lane0_pc_next, lane0_src0, lane0_src1;
    logic [xlen-1:0] lane1_imm, lane1_src0, lane1_src1;
    logic            wb0_en, wb1_en;
    reg_addr_t       wb0_rd, wb1_rd;
    logic [xlen-1:0] wb0_data, wb1_data, wb0_pc;
    logic            redirect_valid, branch_taken;
    logic [xlen-1:0] redirect_pc;

    logic [xlen-1:0] rf [32];     // written only by writeback transfers
    logic [xlen-1:0] arch [32];   // program order, updated at issue
    expect_t         exp_q [$];
    expect_t         head = '0;
    logic            q_empty = 1'b1;
    expect_t         g, acc;
    logic            g_is_br, g_is_mul, g_taken, g_mispred;
    logic [xlen-1:0] g_target, g_link, g_next, a0, b0, a1, b1;
    logic [63:0]     prod;
    logic            fire, xfer, mul_dep;
    reg_addr_t       mul_rd = '0;
    logic [31:0]     lfsr = 32'h1027;
    logic [xlen-1:0] pc_cnt = 32'h1000;
    int              n_sent, n_acc, n_out, cycles, value_errs, other_errs;
    br_cond_t        conds [9] = '{br_jirl, br_b, br_bl, br_beq, br_bne,
                                   br_blt, br_bge, br_bltu, br_bgeu};

    always #20 clk = ~clk;

    exe_top UUT (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [xlen-1:0] alu_model(input alu_op_t op,
                                                  input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_nor:  return ~(a | b);
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $signed(a) >>> b[4:0];
            alu_lui:  return {b[19:0], 12'h000};
            default:  return '0;
        endcase
    endfunction

    function automatic logic cond_model(input br_cond_t c, input logic [xlen-1:0] x,
                                        input logic [xlen-1:0] y);
        case (c)
            br_beq:  return x == y;
            br_bne:  return x != y;
            br_blt:  return $signed(x) < $signed(y);
            br_bge:  return !($signed(x) < $signed(y));
            br_bltu: return x < y;
            br_bgeu: return !(x < y);
            default: return 1'b1;    // jirl, b, bl
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        value_errs++;
        $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
    endtask

    task automatic make_bundle();
        logic [31:0] r;
        logic [2:0]  k;
        k         = 3'(rand_bits(3));
        lane0_en  = rand_bits(3) != 0;
        lane1_en  = rand_bits(3) != 0;
        lane0_rd  = reg_addr_t'(rand_bits(3));    // r0..r7 keeps dependencies dense
        lane0_rj  = reg_addr_t'(rand_bits(3));
        lane0_rk  = reg_addr_t'(rand_bits(3));
        lane1_rd  = reg_addr_t'(rand_bits(3));
        lane1_rj  = reg_addr_t'(rand_bits(3));
        lane1_rk  = reg_addr_t'(rand_bits(3));
        if (lane0_en && lane1_rj == lane0_rd) begin
            lane1_rj = '0;    // issue never pairs these
        end
        if (lane0_en && lane1_rk == lane0_rd) begin
            lane1_rk = '0;
        end
        lane0_uop        = '0;
        lane0_uop.alu_op = alu_op_t'(4'(rand_bits(4) % 12));
        r         = rand_bits(12);
        lane0_imm = {{20{r[11]}}, r[11:0]};
        if (k < 4) begin
            lane0_uop.use_imm = 1'(rand_bits(1));
        end else if (k < 6) begin
            lane0_uop.kind      = kind_mul;
            lane0_uop.mul_hi    = 1'(rand_bits(1));
            lane0_uop.mul_usign = 1'(rand_bits(1));
        end else begin
            lane0_uop.kind = kind_branch;
            lane0_uop.cond = conds[rand_bits(4) % 9];
            r         = rand_bits(6);
            lane0_imm = {{24{r[5]}}, r[5:0], 2'b00};
        end
        lane0_pc      = pc_cnt;
        pc_cnt        = pc_cnt + 32'd8;
        lane0_pc_next = rand_bits(1) ? lane0_pc + 32'd4 : lane0_pc + lane0_imm;
        lane1_uop         = '0;
        lane1_uop.alu_op  = alu_op_t'(4'(rand_bits(4) % 12));
        lane1_uop.use_imm = 1'(rand_bits(1));
        r         = rand_bits(12);
        lane1_imm = {{20{r[11]}}, r[11:0]};
    endtask

    // stale on purpose, in-flight values must come from the bypass
    task automatic drive_sources();
        lane0_src0 = rf[lane0_rj];
        lane0_src1 = rf[lane0_rk];
        lane1_src0 = rf[lane1_rj];
        lane1_src1 = rf[lane1_rk];
    endtask

    // golden results of the bundle now on the inputs
    always_comb begin
        a0 = arch[lane0_rj];
        b0 = arch[lane0_rk];
        a1 = arch[lane1_rj];
        b1 = lane1_uop.use_imm ? lane1_imm : arch[lane1_rk];
        if (lane0_uop.mul_usign) begin
            prod = {32'h0, a0} * {32'h0, b0};
        end else begin
            prod = {{32{a0[31]}}, a0} * {{32{b0[31]}}, b0};
        end
        g_is_br   = lane0_en && lane0_uop.kind == kind_branch;
        g_is_mul  = lane0_en && lane0_uop.kind == kind_mul;
        g_taken   = cond_model(lane0_uop.cond, a0, b0);
        g_target  = ((lane0_uop.cond == br_jirl) ? a0 : lane0_pc) + lane0_imm;
        g_link    = lane0_pc + 32'd4;
        g_next    = g_taken ? g_target : g_link;
        g_mispred = g_is_br && g_next != lane0_pc_next;
        g.en0 = lane0_en;
        g.rd0 = lane0_rd;
        g.pc  = lane0_pc;
        if (lane0_uop.kind == kind_mul) begin
            g.d0 = lane0_uop.mul_hi ? prod[63:32] : prod[31:0];
        end else if (lane0_uop.kind == kind_branch) begin
            g.d0  = g_link;
            g.en0 = lane0_en && (lane0_uop.cond == br_bl || lane0_uop.cond == br_jirl);
        end else begin
            g.d0 = alu_model(lane0_uop.alu_op, a0, lane0_uop.use_imm ? lane0_imm : b0);
        end
        g.en1 = lane1_en && !g_mispred;
        g.rd1 = lane1_rd;
        g.d1  = alu_model(lane1_uop.alu_op, a1, b1);
    end

    assign fire    = in_valid && in_ready;
    assign xfer    = out_valid && out_ready;
    assign mul_dep = mul_rd != '0
        && ((lane0_en && (lane0_rj == mul_rd || lane0_rk == mul_rd))
         || (lane1_en && (lane1_rj == mul_rd || lane1_rk == mul_rd)));

    always @(posedge clk) begin
        if (rstn) begin
            if (xfer) begin
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                if (wb0_en && wb0_rd != '0) begin
                    rf[wb0_rd] = wb0_data;
                end
                if (wb1_en && wb1_rd != '0) begin
                    rf[wb1_rd] = wb1_data;    // lane 1 wins a shared rd
                end
                n_out++;
            end
            if (fire) begin
                acc = g;
                exp_q.push_back(acc);
                mul_rd = (g_is_mul && acc.rd0 != '0 && !(acc.en1 && acc.rd1 == acc.rd0))
                    ? acc.rd0 : '0;
                if (acc.en0 && acc.rd0 != '0) begin
                    arch[acc.rd0] = acc.d0;
                end
                if (acc.en1 && acc.rd1 != '0) begin
                    arch[acc.rd1] = acc.d1;
                end
                n_acc++;
            end
            q_empty <= exp_q.size() == 0;
            if (exp_q.size() != 0) begin
                head <= exp_q[0];
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        $rose(rstn) |-> !out_valid && !redirect_valid && in_ready)
        else begin
            other_errs++;
            $display("%0t: DUT not idle and ready right after reset", $time);
        end

    a_no_orphan: assert property (@(posedge clk) disable iff (!rstn) xfer |-> !q_empty)
        else begin
            other_errs++;
            $display("%0t: writeback transfer with no bundle outstanding", $time);
        end

    a_wb0_en: assert property (@(posedge clk) disable iff (!rstn)
        xfer && !q_empty |-> wb0_en == head.en0)
        else report_mismatch("wb0_en", $sampled(wb0_en), $sampled(head.en0));
    a_wb0_rd: assert property (@(posedge clk) disable iff (!rstn)
        xfer && !q_empty && head.en0 |-> wb0_rd == head.rd0)
        else report_mismatch("wb0_rd", $sampled(wb0_rd), $sampled(head.rd0));
    a_wb0_data: assert property (@(posedge clk) disable iff (!rstn)
        xfer && !q_empty && head.en0 |-> wb0_data == head.d0)
        else report_mismatch("wb0_data", $sampled(wb0_data), $sampled(head.d0));
    a_wb1_en: assert property (@(posedge clk) disable iff (!rstn)
        xfer && !q_empty |-> wb1_en == head.en1)
        else report_mismatch("wb1_en", $sampled(wb1_en), $sampled(head.en1));
    a_wb1_rd: assert property (@(posedge clk) disable iff (!rstn)
        xfer && !q_empty && head.en1 |-> wb1_rd == head.rd1)
        else report_mismatch("wb1_rd", $sampled(wb1_rd), $sampled(head.rd1));
    a_wb1_data: assert property (@(posedge clk) disable iff (!rstn)
        xfer && !q_empty && head.en1 |-> wb1_data == head.d1)
        else report_mismatch("wb1_data", $sampled(wb1_data), $sampled(head.d1));
    a_wb0_pc: assert property (@(posedge clk) disable iff (!rstn)
        xfer && !q_empty |-> wb0_pc == head.pc)
        else report_mismatch("wb0_pc", $sampled(wb0_pc), $sampled(head.pc));

    a_redirect: assert property (@(posedge clk) disable iff (!rstn)
        redirect_valid == (fire && g_mispred))
        else report_mismatch("redirect_valid", $sampled(redirect_valid),
                             $sampled(fire && g_mispred));
    a_redirect_pc: assert property (@(posedge clk) disable iff (!rstn)
        fire && g_mispred |-> redirect_pc == g_next)
        else report_mismatch("redirect_pc", $sampled(redirect_pc), $sampled(g_next));
    a_taken: assert property (@(posedge clk) disable iff (!rstn)
        fire && g_is_br |-> branch_taken == g_taken)
        else report_mismatch("branch_taken", $sampled(branch_taken), $sampled(g_taken));

    // multiply accepted last edge sits in stage 1 now
    a_mul_interlock: assert property (@(posedge clk) disable iff (!rstn)
        $past(fire) && in_valid && mul_dep |-> !in_ready)
        else report_mismatch("in_ready", $sampled(in_ready), 32'd0);

    a_hold: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid
            && $stable({wb0_en, wb0_rd, wb0_data, wb1_en, wb1_rd, wb1_data, wb0_pc}))
        else begin
            other_errs++;
            $display("%0t: writeback outputs changed while out_ready was low", $time);
        end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run not finished after %0d cycles", cycle_limit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rstn      = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        lane0_en  = 1'b0;
        lane1_en  = 1'b0;
        lane0_uop = '0;
        lane1_uop = '0;
        lane0_rd  = '0;
        lane0_rj  = '0;
        lane0_rk  = '0;
        lane1_rd  = '0;
        lane1_rj  = '0;
        lane1_rk  = '0;
        lane0_imm = '0;
        lane1_imm = '0;
        lane0_pc  = '0;
        lane0_pc_next = '0;
        for (int i = 0; i < 32; i++) begin
            rf[i]   = (i == 0) ? '0 : rand_bits(32);
            arch[i] = rf[i];
        end
        drive_sources();
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        while (n_out < n_bundles) begin
            if (in_valid && n_acc == n_sent) begin
                in_valid = 1'b0;
            end
            if (!in_valid && n_sent < n_bundles && rand_bits(3) != 0) begin
                make_bundle();
                in_valid = 1'b1;
                n_sent++;
            end
            drive_sources();
            out_ready = rand_bits(2) != 0;
            @(negedge clk);
        end
        out_ready = 1'b1;
        repeat (4) @(negedge clk);
        if (n_acc != n_out || exp_q.size() != 0) begin
            other_errs++;
            $display("%0d bundles accepted but %0d written back", n_acc, n_out);
        end
        $display("value errors %0d, other errors %0d, bundles in %0d, out %0d",
                 value_errs, other_errs, n_acc, n_out);
        if (value_errs + other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
hdl/exe_pkg.sv
hdl/exe_bypass_if.sv
hdl/exe_alu.sv
hdl/exe_branch.sv
hdl/exe_front.sv
hdl/exe_slot_buf.sv
hdl/exe_back.sv
hdl/exe_top.sv
bench/tb_exe.sv
